/* Makefile */
# Verilator build and run for the ssr adapter testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= sr_adapter_tb
FILELIST  ?= sr_adapter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
PASS_TEXT := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sr_adapter.f */
+incdir+tb
verilog/sr_pkg.sv
verilog/ssr_load_sm.sv
verilog/ssr_serializer.sv
verilog/ssr_receiver.sv
verilog/ssr_parity_check.sv
verilog/sr_adapter.sv
tb/sr_adapter_tb.sv

/* tb/sr_tb_cases.svh */
// ssr adapter test cases
// parity enable, tx word, rx word and sent parity corruption per row
`ifndef SR_TB_CASES_SVH
`define SR_TB_CASES_SVH
`default_nettype none

typedef struct {
  logic       par_en;
  sr_data_t   tx;
  sr_data_t   rx;
  sr_parity_t mask;
} case_t;

localparam int NUM_CASES = 11;

case_t cases [NUM_CASES];

// parity-on rows first, then parity-off rows
// masks on the first two accepted frames must not show up as flags
task automatic load_cases();
  cases[0]  = '{1'b1, 32'hdead_beef, 32'h1234_5678, 2'b01};
  cases[1]  = '{1'b1, 32'h0000_0001, 32'h8000_0000, 2'b10};
  cases[2]  = '{1'b1, 32'hffff_ffff, 32'h0f0f_f0f0, 2'b00};
  cases[3]  = '{1'b1, 32'ha5a5_5a5a, 32'h0001_0001, 2'b01};
  cases[4]  = '{1'b1, 32'h8000_0000, 32'hcafe_f00d, 2'b10};
  cases[5]  = '{1'b1, 32'h0123_4567, 32'hffff_0000, 2'b11};
  // without parity the mask has nothing to corrupt
  cases[6]  = '{1'b0, 32'h89ab_cdef, 32'h5555_aaaa, 2'b11};
  cases[7]  = '{1'b0, 32'h0000_0000, 32'hffff_ffff, 2'b01};
  cases[8]  = '{1'b0, 32'h7fff_fffe, 32'h0000_0003, 2'b00};
  cases[9]  = '{1'b0, 32'h1357_9bdf, 32'hc000_0001, 2'b10};
  cases[10] = '{1'b0, 32'hfeed_face, 32'h2468_ace0, 2'b11};
endtask

`default_nettype wire
`endif

/* tb/sr_adapter_tb.sv */
// ssr adapter testbench
// runs both serial paths from a case table, checks frames, words and parity flags
`timescale 1ns/1ps
`default_nettype none

module sr_adapter_tb
  import sr_pkg::*;
;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 16;
  localparam int SEED          = 32'hb9a1_609f;

  logic                      sr_clock_rx_osc_clk;
  logic                      sr_reset_rx_osc_clk_rst_n;
  logic                      r_sr_parity_en;
  logic                      osc_transfer_en;
  logic [SR_DATA_W-1:0]      tx_parallel_data;
  logic                      aib_fabric_ssr_data_in;
  logic                      aib_fabric_ssr_load_in;
  logic                      aib_fabric_ssr_data_out;
  logic                      aib_fabric_ssr_load_out;
  logic [SR_DATA_W-1:0]      rx_parallel_data;
  logic                      ssr_update_load;
  logic [SR_PARITY_BITS-1:0] sr_parity_error_flag;

  // values applied at the next drive point, and expected held outputs
  logic       drv_en;
  sr_data_t   drv_tx;
  sr_data_t   exp_rx;
  sr_parity_t exp_flags;
  int         errors;

  `include "sr_tb_cases.svh"

  // two frame periods per row, with margin, plus both resets
  localparam int WATCHDOG_NS = 2 * NUM_CASES * 2 * (SR_FRAME_W + 1) * CLK_PERIOD_NS
                             + 2 * RESET_CYCLES * CLK_PERIOD_NS;

  sr_adapter uut (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .r_sr_parity_en            (r_sr_parity_en),
    .osc_transfer_en           (osc_transfer_en),
    .tx_parallel_data          (tx_parallel_data),
    .aib_fabric_ssr_data_in    (aib_fabric_ssr_data_in),
    .aib_fabric_ssr_load_in    (aib_fabric_ssr_load_in),
    .aib_fabric_ssr_data_out   (aib_fabric_ssr_data_out),
    .aib_fabric_ssr_load_out   (aib_fabric_ssr_load_out),
    .rx_parallel_data          (rx_parallel_data),
    .ssr_update_load           (ssr_update_load),
    .sr_parity_error_flag      (sr_parity_error_flag)
  );

  always #(CLK_PERIOD_NS / 2) sr_clock_rx_osc_clk = ~sr_clock_rx_osc_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("ERR t=%0t %s expected=%b actual=%b", $time, name, exp, act);
      errors++;
      fail_run("stopping at the first mismatch");
    end
  endtask

  task automatic check_data(input string name, input sr_data_t act, input sr_data_t exp);
    if (act !== exp)
    begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
      fail_run("stopping at the first mismatch");
    end
  endtask

  task automatic check_flags(input string name, input sr_parity_t act, input sr_parity_t exp);
    if (act !== exp)
    begin
      $display("ERR t=%0t %s expected=%b actual=%b", $time, name, exp, act);
      errors++;
      fail_run("stopping at the first mismatch");
    end
  endtask

  // frame bits msb first, zeros trail a word sent without parity
  function automatic logic [SR_FRAME_W-1:0] build_frame(input logic par_en,
                                                       input sr_data_t word,
                                                       input sr_parity_t mask);
    sr_frame_t f;
    f.parity = sr_group_parity(word) ^ mask;
    f.data   = word;
    if (par_en)
      return f;
    return {word, {SR_PARITY_BITS{1'b0}}};
  endfunction

  // one clock: check held outputs, drive inputs, then check the update strobe
  task automatic run_cycle(input logic data_bit, input logic load_bit, input logic exp_dout,
                           input logic exp_lout, input logic exp_upd);
    @(posedge sr_clock_rx_osc_clk);
    #1;
    check_bit("aib_fabric_ssr_data_out", aib_fabric_ssr_data_out, exp_dout);
    check_bit("aib_fabric_ssr_load_out", aib_fabric_ssr_load_out, exp_lout);
    check_data("rx_parallel_data", rx_parallel_data, exp_rx);
    check_flags("sr_parity_error_flag", sr_parity_error_flag, exp_flags);
    osc_transfer_en        = drv_en;
    tx_parallel_data       = drv_tx;
    aib_fabric_ssr_data_in = data_bit;
    aib_fabric_ssr_load_in = load_bit;
    #1;
    check_bit("ssr_update_load", ssr_update_load, exp_upd);
  endtask

  task automatic apply_reset(input logic par_en);
    @(posedge sr_clock_rx_osc_clk);
    #1;
    sr_reset_rx_osc_clk_rst_n = 1'b0;
    r_sr_parity_en            = par_en;
    drv_en                    = 1'b0;
    drv_tx                    = '0;
    osc_transfer_en           = 1'b0;
    tx_parallel_data          = '0;
    aib_fabric_ssr_data_in    = 1'b0;
    aib_fabric_ssr_load_in    = 1'b0;
    repeat (RESET_CYCLES) @(posedge sr_clock_rx_osc_clk);
    #1;
    sr_reset_rx_osc_clk_rst_n = 1'b1;
  endtask

  task automatic run_half(input logic par_en);
    int                    idx[$];
    int                    nrows;
    int                    len;
    sr_data_t              rx_word;
    sr_parity_t            rx_mask;
    logic [SR_FRAME_W-1:0] tx_f;
    logic [SR_FRAME_W-1:0] rx_f;
    for (int i = 0; i < NUM_CASES; i++)
    begin
      if (cases[i].par_en == par_en)
        idx.push_back(i);
    end
    nrows = idx.size();
    len   = par_en ? SR_FRAME_W : SR_DATA_W;
    apply_reset(par_en);
    exp_rx    = '0;
    exp_flags = '0;

    // quiet outputs and no load while transfers are off
    repeat (4) run_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    drv_tx = cases[idx[0]].tx;
    drv_en = 1'b1;
    run_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // first load follows the enable sample
    run_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);

    for (int j = 0; j <= nrows; j++)
    begin
      // inbound frame 0 is filler that the receiver must drop
      if (j == 0)
      begin
        rx_word = $urandom();
        rx_mask = '0;
      end
      else
      begin
        rx_word = cases[idx[j-1]].rx;
        rx_mask = cases[idx[j-1]].mask;
      end
      rx_f = build_frame(par_en, rx_word, rx_mask);
      tx_f = (j < nrows) ? build_frame(par_en, cases[idx[j]].tx, '0) : '0;
      for (int k = 1; k <= len; k++)
      begin
        if (k == 1)
        begin
          drv_tx = (j + 1 < nrows) ? cases[idx[j+1]].tx : $urandom();
          if (j == nrows - 1)
            drv_en = 1'b0;
        end
        run_cycle(rx_f[SR_FRAME_W-k], 1'b0, tx_f[SR_FRAME_W-k], 1'b0, 1'b0);
      end
      // shared load cycle for the next outbound frame and this inbound one
      run_cycle(1'b0, 1'b1, 1'b0, (j + 1 < nrows), (j >= 1));
      if (j >= 1)
      begin
        exp_rx = rx_word;
        // checking starts at the third accepted frame
        if (par_en && (j - 1) >= 2)
          exp_flags = rx_mask;
        else
          exp_flags = '0;
      end
    end
    repeat (2) run_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  initial
  begin : main
    sr_clock_rx_osc_clk       = 1'b0;
    sr_reset_rx_osc_clk_rst_n = 1'b0;
    r_sr_parity_en            = 1'b0;
    osc_transfer_en           = 1'b0;
    tx_parallel_data          = '0;
    aib_fabric_ssr_data_in    = 1'b0;
    aib_fabric_ssr_load_in    = 1'b0;
    drv_en                    = 1'b0;
    drv_tx                    = '0;
    exp_rx                    = '0;
    exp_flags                 = '0;
    errors                    = 0;
    void'($urandom(SEED));
    load_cases();
    run_half(1'b1);
    run_half(1'b0);
    if (errors == 0)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      fail_run("checks failed during the run");
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire

/* verilog/sr_adapter.sv */
// slow serial-register adapter top
// outbound load sequencer and serializer, inbound receiver and parity check
`timescale 1ns/1ps
`default_nettype none

module sr_adapter
  import sr_pkg::*;
(
  input  logic                      sr_clock_rx_osc_clk,
  input  logic                      sr_reset_rx_osc_clk_rst_n,
  input  logic                      r_sr_parity_en,
  input  logic                      osc_transfer_en,
  input  logic [SR_DATA_W-1:0]      tx_parallel_data,
  // die interface
  input  logic                      aib_fabric_ssr_data_in,
  input  logic                      aib_fabric_ssr_load_in,
  output logic                      aib_fabric_ssr_data_out,
  output logic                      aib_fabric_ssr_load_out,
  // fabric side
  output logic [SR_DATA_W-1:0]      rx_parallel_data,
  output logic                      ssr_update_load,
  output logic [SR_PARITY_BITS-1:0] sr_parity_error_flag
);

  sr_frame_t rx_frame;

  // outbound load pacing
  ssr_load_sm ssr_load_sm (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .r_sr_parity_en            (r_sr_parity_en),
    .osc_transfer_en           (osc_transfer_en),
    .sr_load                   (aib_fabric_ssr_load_out)
  );

  // outbound shifter toward the die
  ssr_serializer ssr_serializer (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .r_sr_parity_en            (r_sr_parity_en),
    .sr_load                   (aib_fabric_ssr_load_out),
    .sr_parallel_in            (tx_parallel_data),
    .sr_serial_out             (aib_fabric_ssr_data_out)
  );

  // inbound chain, raw load from the die
  ssr_receiver ssr_receiver (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .sr_serial_in              (aib_fabric_ssr_data_in),
    .sr_load                   (aib_fabric_ssr_load_in),
    .sr_update                 (ssr_update_load),
    .sr_frame                  (rx_frame)
  );

  ssr_parity_check ssr_parity_check (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .r_sr_parity_en            (r_sr_parity_en),
    .sr_update                 (ssr_update_load),
    .sr_frame                  (rx_frame),
    .sr_parity_error_flag      (sr_parity_error_flag)
  );

  assign rx_parallel_data = rx_frame.data;

endmodule

`default_nettype wire

/* verilog/sr_pkg.sv */
// slow serial-register shared definitions
// widths, frame layout and group parity for the ssr adapter
`default_nettype none

package sr_pkg;

  // parallel word and parity grouping
  localparam int SR_DATA_W      = 32;
  localparam int SR_GROUP_W     = 16;
  localparam int SR_PARITY_BITS = SR_DATA_W / SR_GROUP_W;
  localparam int SR_FRAME_W     = SR_DATA_W + SR_PARITY_BITS;

  // counter wide enough to reach the longest frame
  localparam int SR_CNT_W = $clog2(SR_FRAME_W + 1);

  typedef logic [SR_DATA_W-1:0]      sr_data_t;
  typedef logic [SR_PARITY_BITS-1:0] sr_parity_t;
  typedef logic [SR_CNT_W-1:0]       sr_cnt_t;

  // parity sits above data, so it leaves the shifter first
  typedef struct packed {
    sr_parity_t parity;
    sr_data_t   data;
  } sr_frame_t;

  // frame lengths in bit times, with and without parity
  localparam sr_cnt_t SR_LEN_PAR   = sr_cnt_t'(SR_FRAME_W);
  localparam sr_cnt_t SR_LEN_NOPAR = sr_cnt_t'(SR_DATA_W);

  // even parity per group, group 0 is the low half
  function automatic sr_parity_t sr_group_parity(input sr_data_t data);
    sr_parity_t par;
    par = '0;
    for (int i = 0; i < SR_PARITY_BITS; i++)
    begin
      par[i] = ^data[i*SR_GROUP_W +: SR_GROUP_W];
    end
    return par;
  endfunction

endpackage

`default_nettype wire

/* verilog/ssr_load_sm.sv */
// ssr load sequencer
// paces one load strobe per frame period while transfers are enabled
`timescale 1ns/1ps
`default_nettype none

module ssr_load_sm
  import sr_pkg::*;
(
  input  logic sr_clock_rx_osc_clk,
  input  logic sr_reset_rx_osc_clk_rst_n,
  input  logic r_sr_parity_en,
  input  logic osc_transfer_en,
  output logic sr_load
);

  typedef enum logic {ST_IDLE, ST_RUN} state_t;

  state_t  state_q;
  sr_cnt_t bit_cnt_q;
  sr_cnt_t frame_len;
  logic    period_end;

  assign frame_len  = r_sr_parity_en ? SR_LEN_PAR : SR_LEN_NOPAR;
  // last cycle of the period, one past the frame bits
  assign period_end = (bit_cnt_q == frame_len);

  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      state_q   <= ST_IDLE;
      bit_cnt_q <= '0;
      sr_load   <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          bit_cnt_q <= '0;
          sr_load   <= osc_transfer_en;
          if (osc_transfer_en)
            state_q <= ST_RUN;
        end
        ST_RUN:
        begin
          if (period_end)
          begin
            bit_cnt_q <= '0;
            // frame done, reload only if still enabled
            sr_load   <= osc_transfer_en;
            if (!osc_transfer_en)
              state_q <= ST_IDLE;
          end
          else
          begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            sr_load   <= 1'b0;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
          sr_load <= 1'b0;
        end
      endcase
    end
  end

  // load is a single-cycle strobe
  a_load_one_cycle: assert property (
    @(posedge sr_clock_rx_osc_clk) disable iff (!sr_reset_rx_osc_clk_rst_n)
    sr_load |=> !sr_load
  );

endmodule

`default_nettype wire

/* verilog/ssr_parity_check.sv */
// ssr inbound parity checker
// flags per-group parity errors from the third accepted frame on
`timescale 1ns/1ps
`default_nettype none

module ssr_parity_check
  import sr_pkg::*;
(
  input  logic       sr_clock_rx_osc_clk,
  input  logic       sr_reset_rx_osc_clk_rst_n,
  input  logic       r_sr_parity_en,
  input  logic       sr_update,
  input  sr_frame_t  sr_frame,
  output sr_parity_t sr_parity_error_flag
);

  logic       qual_dly0_q;
  logic       qual_q;
  logic       chk_q;
  sr_parity_t calc_parity;

  // qualifiers open after two accepted frames
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      qual_dly0_q <= 1'b0;
      qual_q      <= 1'b0;
    end
    else
    begin
      if (!qual_dly0_q)
        qual_dly0_q <= sr_update;
      if (!qual_q)
        qual_q <= sr_update && qual_dly0_q;
    end
  end

  // check enable follows each update and holds with the frame register
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      chk_q <= 1'b0;
    end
    else
    begin
      if (!r_sr_parity_en)
        chk_q <= 1'b0;
      else if (sr_update)
        chk_q <= qual_q;
    end
  end

  // compare received parity against the captured word
  assign calc_parity          = sr_group_parity(sr_frame.data);
  assign sr_parity_error_flag = (sr_frame.parity ^ calc_parity)
                              & {SR_PARITY_BITS{chk_q}};

  a_no_flags_without_parity: assert property (
    @(posedge sr_clock_rx_osc_clk) disable iff (!sr_reset_rx_osc_clk_rst_n)
    !r_sr_parity_en |-> (sr_parity_error_flag == '0)
  );

endmodule

`default_nettype wire

/* verilog/ssr_receiver.sv */
// ssr inbound receiver
// drops the first load after reset and deserializes frames into words
`timescale 1ns/1ps
`default_nettype none

module ssr_receiver
  import sr_pkg::*;
(
  input  logic      sr_clock_rx_osc_clk,
  input  logic      sr_reset_rx_osc_clk_rst_n,
  input  logic      sr_serial_in,
  input  logic      sr_load,
  output logic      sr_update,
  output sr_frame_t sr_frame
);

  logic                  load_dly_q;
  logic                  arm_q;
  logic [SR_FRAME_W-1:0] shift_q;
  sr_frame_t             frame_q;

  // load qualification
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      load_dly_q <= 1'b0;
      arm_q      <= 1'b0;
    end
    else
    begin
      load_dly_q <= sr_load;
      // sticky once the first pulse has fallen
      if (!arm_q)
        arm_q <= load_dly_q && !sr_load;
    end
  end

  assign sr_update = arm_q & sr_load;

  // bits arrive in the cycles between loads
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_load)
      shift_q <= {shift_q[SR_FRAME_W-2:0], sr_serial_in};
  end

  // holding register, new word from the cycle after the update
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      frame_q <= '0;
    end
    else
    begin
      if (sr_update)
        frame_q <= shift_q;
    end
  end

  assign sr_frame = frame_q;

  a_update_needs_load: assert property (
    @(posedge sr_clock_rx_osc_clk) disable iff (!sr_reset_rx_osc_clk_rst_n)
    sr_update |-> sr_load
  );

endmodule

`default_nettype wire

/* verilog/ssr_serializer.sv */
// ssr outbound serializer
// captures the word at load and shifts the frame out msb first
`timescale 1ns/1ps
`default_nettype none

module ssr_serializer
  import sr_pkg::*;
(
  input  logic     sr_clock_rx_osc_clk,
  input  logic     sr_reset_rx_osc_clk_rst_n,
  input  logic     r_sr_parity_en,
  input  logic     sr_load,
  input  sr_data_t sr_parallel_in,
  output logic     sr_serial_out
);

  sr_frame_t             par_frame;
  logic [SR_FRAME_W-1:0] frame_bits;
  logic [SR_FRAME_W-1:0] shift_q;
  logic                  load_seen_q;

  assign par_frame.parity = sr_group_parity(sr_parallel_in);
  assign par_frame.data   = sr_parallel_in;

  // without parity the word leads and zeros trail
  assign frame_bits = r_sr_parity_en ? par_frame
                                     : {sr_parallel_in, {SR_PARITY_BITS{1'b0}}};

  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      shift_q     <= '0;
      load_seen_q <= 1'b0;
    end
    else
    begin
      if (sr_load)
        shift_q <= frame_bits;
      else
        shift_q <= {shift_q[SR_FRAME_W-2:0], 1'b0};
      if (sr_load)
        load_seen_q <= 1'b1;
    end
  end

  // zeros fill in behind the frame, so the line idles low
  assign sr_serial_out = shift_q[SR_FRAME_W-1];

  // quiet line until the sequencer issues its first load
  a_quiet_before_load: assert property (
    @(posedge sr_clock_rx_osc_clk) disable iff (!sr_reset_rx_osc_clk_rst_n)
    !load_seen_q |-> !sr_serial_out
  );

endmodule

`default_nettype wire
